//--- dv/decode_stage_properties.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_stage_properties (
    input logic                  i_clock,
    input logic                  i_reset,
    input logic                  i_inst_valid,
    input logic                  o_inst_ready,
    input logic [`NB_INST-1:0]   i_inst,
    input logic                  o_dec_valid,
    input logic                  i_dec_ready,
    input pipe_pkg::alu_op_e     o_alu_op,
    input logic                  o_hlt,
    input logic [`NB_DATA-1:0]   o_data_a,
    input logic [`NB_DATA-1:0]   o_data_b,
    input logic [`NB_DATA-1:0]   o_immediate,
    input logic [`NB_PC-1:0]     o_jump_address,
    input logic [`NB_PC-1:0]     o_pc
);
    import isa_pkg::*;

    logic halted;                              // Halt accepted since reset

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            halted <= 1'b0;
        end else if (i_inst_valid && o_inst_ready && (i_inst[31:26] == OP_HALT)) begin
            halted <= 1'b1;
        end
    end

    valid_low_after_reset: assert property (@(posedge i_clock) i_reset |=> !o_dec_valid)
        else $error("o_dec_valid high right after a reset cycle");

    output_held: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_dec_valid && !i_dec_ready) |=> (o_dec_valid && $stable(o_alu_op) && $stable(o_hlt)
            && $stable(o_data_a) && $stable(o_data_b) && $stable(o_immediate)
            && $stable(o_jump_address) && $stable(o_pc)))
        else $error("decoded bundle changed or dropped under back-pressure");

    ready_low_when_halted: assert property (@(posedge i_clock) disable iff (i_reset)
        halted |-> !o_inst_ready)
        else $error("o_inst_ready high in the halted state");

endmodule

bind decode_stage decode_stage_properties u_properties (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_inst_valid   (i_inst_valid),
    .o_inst_ready   (o_inst_ready),
    .i_inst         (i_inst),
    .o_dec_valid    (o_dec_valid),
    .i_dec_ready    (i_dec_ready),
    .o_alu_op       (o_alu_op),
    .o_hlt          (o_hlt),
    .o_data_a       (o_data_a),
    .o_data_b       (o_data_b),
    .o_immediate    (o_immediate),
    .o_jump_address (o_jump_address),
    .o_pc           (o_pc)
);

//--- dv/decode_stage_tb.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_stage_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic                reg_dest;
        alu_op_e             alu_op;
        logic                alu_src;
        logic                mem_read;
        logic                mem_write;
        logic                branch;
        logic                reg_write;
        logic                mem_to_reg;
        logic                jump;
        logic                jr_jalr;
        logic                hlt;
        mem_size_e           mem_size;
        logic [`NB_DATA-1:0] data_a;
        logic [`NB_DATA-1:0] data_b;
        logic [`NB_DATA-1:0] immediate;
        logic [`NB_DATA-1:0] shamt;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [`NB_PC-1:0]   jump_address;
        logic [`NB_PC-1:0]   pc;
    } bundle_t;

    // Legal opcodes without HALT, which is sent on its own
    localparam logic [5:0] op_list [14] = '{OP_RTYPE, OP_LB, OP_LH, OP_LW, OP_SB, OP_SH,
                                            OP_SW, OP_ADDI, OP_ANDI, OP_ORI, OP_BEQ,
                                            OP_BNE, OP_J, OP_JAL};
    localparam logic [5:0] funct_list [8] = '{F_ADD, F_SUB, F_AND, F_OR, F_SLT, F_SLL,
                                              F_JR, F_JALR};

    logic                i_clock;
    logic                i_reset;
    logic                i_inst_valid;
    logic                o_inst_ready;
    logic [`NB_INST-1:0] i_inst;
    logic [`NB_PC-1:0]   i_next_pc;
    logic                i_wb_write;
    reg_addr_t           i_wb_reg;
    logic [`NB_DATA-1:0] i_wb_data;
    logic                o_dec_valid;
    logic                i_dec_ready;
    logic                o_reg_dest;
    alu_op_e             o_alu_op;
    logic                o_alu_src;
    logic                o_mem_read;
    logic                o_mem_write;
    logic                o_branch;
    logic                o_reg_write;
    logic                o_mem_to_reg;
    logic                o_jump;
    logic                o_jr_jalr;
    logic                o_hlt;
    mem_size_e           o_mem_size;
    logic [`NB_DATA-1:0] o_data_a;
    logic [`NB_DATA-1:0] o_data_b;
    logic [`NB_DATA-1:0] o_immediate;
    logic [`NB_DATA-1:0] o_shamt;
    reg_addr_t           o_rt;
    reg_addr_t           o_rd;
    logic [`NB_PC-1:0]   o_jump_address;
    logic [`NB_PC-1:0]   o_pc;

    integer              seed;
    bit                  wb_enable;
    bit                  ready_toggle;
    logic [`NB_DATA-1:0] shadow [`N_REGS];   // Expected register bank
    bundle_t             expected_q [$];
    int                  accepts;
    bit                  halted;
    bit                  was_reset;

    decode_stage u_dut (.*);

    always #5 i_clock = ~i_clock;

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Verification failed");
        $fatal(1, "Testbench stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "Testbench stopped");
        end
    endtask

    function automatic mem_size_e access_size(input logic [5:0] op);
        case (op)
            OP_LB, OP_SB: return SZ_BYTE;
            OP_LH, OP_SH: return SZ_HALF;
            default:      return SZ_WORD;
        endcase
    endfunction

    // Reference decode of one instruction from the rule table
    function automatic bundle_t expect_bundle(input logic [31:0] inst, input logic [31:0] pc,
                                              input logic [31:0] a, input logic [31:0] b);
        bundle_t    e;
        logic [5:0] op;
        logic [5:0] fn;
        logic       legal;
        op = inst[31:26];
        fn = inst[5:0];
        legal = 1'b1;
        e = '0;
        e.alu_op = ALU_NOP;
        e.mem_size = SZ_NONE;
        case (op)
            OP_RTYPE: begin
                case (fn)
                    F_ADD:   e.alu_op = ALU_ADD;
                    F_SUB:   e.alu_op = ALU_SUB;
                    F_AND:   e.alu_op = ALU_AND;
                    F_OR:    e.alu_op = ALU_OR;
                    F_SLT:   e.alu_op = ALU_SLT;
                    F_SLL:   e.alu_op = ALU_SLL;
                    F_JR,
                    F_JALR:  e.jr_jalr = 1'b1;
                    default: legal = 1'b0;     // Unknown funct is a bubble
                endcase
                e.reg_dest = legal;
                e.reg_write = legal && (fn != F_JR);
            end
            OP_LB, OP_LH, OP_LW: begin
                e.alu_src = 1'b1;
                e.mem_read = 1'b1;
                e.reg_write = 1'b1;
                e.mem_to_reg = 1'b1;
                e.alu_op = ALU_ADD;
                e.mem_size = access_size(op);
            end
            OP_SB, OP_SH, OP_SW: begin
                e.alu_src = 1'b1;
                e.mem_write = 1'b1;
                e.alu_op = ALU_ADD;
                e.mem_size = access_size(op);
            end
            OP_ADDI: begin
                e.alu_src = 1'b1;
                e.reg_write = 1'b1;
                e.alu_op = ALU_ADD;
            end
            OP_ANDI: begin
                e.alu_src = 1'b1;
                e.reg_write = 1'b1;
                e.alu_op = ALU_AND;
            end
            OP_ORI: begin
                e.alu_src = 1'b1;
                e.reg_write = 1'b1;
                e.alu_op = ALU_OR;
            end
            OP_BEQ, OP_BNE: begin
                e.branch = 1'b1;
                e.alu_op = ALU_SUB;
            end
            OP_J:    e.jump = 1'b1;
            OP_JAL: begin
                e.jump = 1'b1;
                e.reg_write = 1'b1;
            end
            OP_HALT: e.hlt = 1'b1;
            default: e.alu_op = ALU_NOP;
        endcase
        e.data_a = a;
        e.data_b = b;
        e.immediate = {{16{inst[15]}}, inst[15:0]};
        e.shamt = {27'd0, inst[10:6]};
        e.rt = inst[20:16];
        e.rd = inst[15:11];
        e.jump_address = {pc[31:28], inst[25:0], 2'b00};
        e.pc = pc;
        return e;
    endfunction

    // Register read as seen on the accept edge, with writeback bypass
    function automatic logic [31:0] read_operand(input reg_addr_t r);
        if (r == '0) begin
            return '0;
        end else if (i_wb_write && (i_wb_reg == r)) begin
            return i_wb_data;
        end
        return shadow[r];
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] inst;
        logic [31:0] pick;
        inst = $random(seed);
        pick = $random(seed);
        if (pick[3:0] < 4'd14) begin
            inst[31:26] = op_list[pick[3:0]];
        end else if (pick[3:0] == 4'd14) begin
            inst[31:26] = OP_RTYPE;
        end else if (inst[31:26] == OP_HALT) begin
            inst[31:26] = 6'h3e;               // Keep random codes away from HALT
        end
        if ((inst[31:26] == OP_RTYPE) && (pick[9:8] != 2'b00)) begin
            inst[5:0] = funct_list[pick[7:5]];
        end
        return inst;
    endfunction

    task automatic compare_bundle(input bundle_t e);
        compare_value("o_reg_dest", 32'(o_reg_dest), 32'(e.reg_dest));
        compare_value("o_alu_op", 32'(o_alu_op), 32'(e.alu_op));
        compare_value("o_alu_src", 32'(o_alu_src), 32'(e.alu_src));
        compare_value("o_mem_read", 32'(o_mem_read), 32'(e.mem_read));
        compare_value("o_mem_write", 32'(o_mem_write), 32'(e.mem_write));
        compare_value("o_branch", 32'(o_branch), 32'(e.branch));
        compare_value("o_reg_write", 32'(o_reg_write), 32'(e.reg_write));
        compare_value("o_mem_to_reg", 32'(o_mem_to_reg), 32'(e.mem_to_reg));
        compare_value("o_jump", 32'(o_jump), 32'(e.jump));
        compare_value("o_jr_jalr", 32'(o_jr_jalr), 32'(e.jr_jalr));
        compare_value("o_hlt", 32'(o_hlt), 32'(e.hlt));
        compare_value("o_mem_size", 32'(o_mem_size), 32'(e.mem_size));
        compare_value("o_data_a", o_data_a, e.data_a);
        compare_value("o_data_b", o_data_b, e.data_b);
        compare_value("o_immediate", o_immediate, e.immediate);
        compare_value("o_shamt", o_shamt, e.shamt);
        compare_value("o_rt", 32'(o_rt), 32'(e.rt));
        compare_value("o_rd", 32'(o_rd), 32'(e.rd));
        compare_value("o_jump_address", o_jump_address, e.jump_address);
        compare_value("o_pc", o_pc, e.pc);
    endtask

    // Scoreboard sees the values from before this edge
    always @(posedge i_clock) begin
        bundle_t     expected;
        logic [31:0] a;
        logic [31:0] b;
        if (i_reset) begin
            for (int r = 0; r < `N_REGS; r++) begin
                shadow[r] = '0;
            end
            expected_q.delete();
            accepts = 0;
            halted = 1'b0;
        end else begin
            if (was_reset && !o_inst_ready) begin
                abort_run("o_inst_ready was low in the first cycle after reset");
            end
            if (o_dec_valid && (accepts == 0)) begin
                abort_run("o_dec_valid went high before any instruction was accepted");
            end
            if (halted && o_inst_ready) begin
                abort_run("o_inst_ready went high after a halt instruction was accepted");
            end
            if (o_dec_valid && i_dec_ready) begin
                if (expected_q.size() == 0) begin
                    abort_run("a decoded bundle came out with no instruction pending");
                end else begin
                    expected = expected_q.pop_front();
                    compare_bundle(expected);
                end
            end
            if (i_inst_valid && o_inst_ready) begin
                a = read_operand(i_inst[25:21]);
                b = read_operand(i_inst[20:16]);
                expected_q.push_back(expect_bundle(i_inst, i_next_pc, a, b));
                accepts++;
                if (i_inst[31:26] == OP_HALT) begin
                    halted = 1'b1;
                end
            end
            if (i_wb_write && (i_wb_reg != '0)) begin
                shadow[i_wb_reg] = i_wb_data;   // Register 0 keeps zero
            end
        end
        was_reset = i_reset;
    end

    // Advance one edge, then drive writeback and output ready
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge i_clock);
        rnd = $random(seed);
        i_wb_write  <= wb_enable && rnd[0];
        i_wb_reg    <= rnd[5:1];
        i_wb_data   <= $random(seed);
        i_dec_ready <= !ready_toggle || (rnd[7:6] != 2'b00);
    endtask

    task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
        int waited;
        i_inst_valid <= 1'b1;
        i_inst       <= inst;
        i_next_pc    <= pc;
        waited = 0;
        do begin
            if (waited == 200) begin
                abort_run("an instruction was not accepted within 200 cycles");
            end
            waited++;
            next_cycle();
        end while (!o_inst_ready);
    endtask

    task automatic send_random();
        logic [31:0] gap;
        send_inst(random_inst(), $random(seed));
        gap = $random(seed);
        if (gap[1:0] == 2'b00) begin
            i_inst_valid <= 1'b0;               // Idle cycle on the input
            next_cycle();
        end
    endtask

    task automatic wait_drained();
        int waited;
        i_inst_valid <= 1'b0;
        waited = 0;
        @(negedge i_clock);
        while (expected_q.size() != 0) begin
            if (waited == 200) begin
                abort_run("decoded bundles did not leave the stage within 200 cycles");
            end
            waited++;
            next_cycle();
            @(negedge i_clock);
        end
        next_cycle();
    endtask

    initial begin
        seed = 63145;
        i_clock = 1'b0;
        i_reset = 1'b1;
        i_inst_valid = 1'b0;
        i_inst = '0;
        i_next_pc = '0;
        i_wb_write = 1'b0;
        i_wb_reg = '0;
        i_wb_data = '0;
        i_dec_ready = 1'b1;
        wb_enable = 1'b0;
        ready_toggle = 1'b0;
        was_reset = 1'b0;
        repeat (3) @(posedge i_clock);
        i_reset <= 1'b0;

        repeat (20) send_random();              // Bank still all zero
        wait_drained();

        wb_enable = 1'b1;
        ready_toggle = 1'b1;
        repeat (600) send_random();
        wait_drained();

        send_inst({OP_HALT, 26'h2a55a5}, 32'h9000_0040);
        i_inst <= random_inst();                // Offered but never taken
        repeat (20) next_cycle();
        wait_drained();

        // Restart after halt with a cleared bank
        wb_enable = 1'b0;
        i_reset <= 1'b1;
        repeat (3) next_cycle();
        i_reset <= 1'b0;
        repeat (10) send_random();
        wait_drained();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- hdl/decode_control.sv
`timescale 1ns/10ps

module decode_control (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_inst_valid,
    output logic             o_inst_ready,
    input  isa_pkg::opcode_e i_opcode,
    input  isa_pkg::funct_e  i_funct,
    decode_ctrl_if.ctrl      ctrl
);
    import isa_pkg::*;
    import pipe_pkg::*;

    dec_state_e state;

    assign o_inst_ready = (state == ST_RUN) && ctrl.out_free;
    assign ctrl.load    = i_inst_valid && o_inst_ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_RUN;
        end else if (ctrl.load && ctrl.hlt) begin
            state <= ST_HALTED;        // Halt bundle still goes out
        end
    end

    always_comb begin
        ctrl.reg_dest   = 1'b0;        // Unknown codes decode to a bubble
        ctrl.alu_op     = ALU_NOP;
        ctrl.alu_src    = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jr_jalr    = 1'b0;
        ctrl.hlt        = 1'b0;
        ctrl.mem_size   = SZ_NONE;

        case (i_opcode)
            OP_RTYPE: begin
                if (i_funct inside {F_ADD, F_SUB, F_AND, F_OR, F_SLT, F_SLL, F_JR, F_JALR}) begin
                    ctrl.reg_dest  = 1'b1;
                    ctrl.reg_write = (i_funct != F_JR); // JR has no result
                end
                case (i_funct)
                    F_ADD:   ctrl.alu_op = ALU_ADD;
                    F_SUB:   ctrl.alu_op = ALU_SUB;
                    F_AND:   ctrl.alu_op = ALU_AND;
                    F_OR:    ctrl.alu_op = ALU_OR;
                    F_SLT:   ctrl.alu_op = ALU_SLT;
                    F_SLL:   ctrl.alu_op = ALU_SLL;
                    F_JR,
                    F_JALR:  ctrl.jr_jalr = 1'b1; // Target from rs, ALU idle
                    default: ctrl.alu_op = ALU_NOP;
                endcase
            end
            OP_LB, OP_LH, OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = ALU_ADD;      // Base plus offset
                ctrl.mem_size   = (i_opcode == OP_LB) ? SZ_BYTE :
                                  (i_opcode == OP_LH) ? SZ_HALF : SZ_WORD;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_write  = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                ctrl.mem_size   = (i_opcode == OP_SB) ? SZ_BYTE :
                                  (i_opcode == OP_SH) ? SZ_HALF : SZ_WORD;
            end
            OP_ADDI, OP_ANDI, OP_ORI: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = (i_opcode == OP_ADDI) ? ALU_ADD :
                                  (i_opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch     = 1'b1;
                ctrl.alu_op     = ALU_SUB;      // Compare by subtraction
            end
            OP_J: begin
                ctrl.jump       = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump       = 1'b1;
                ctrl.reg_write  = 1'b1;         // Link register write
            end
            OP_HALT: begin
                ctrl.hlt        = 1'b1;
            end
            default: begin
                ctrl.alu_op     = ALU_NOP;
            end
        endcase
    end

endmodule

//--- hdl/decode_ctrl_if.sv
`timescale 1ns/10ps

interface decode_ctrl_if;
    import pipe_pkg::*;

    logic      load;                   // Capture the bundle this cycle
    logic      out_free;               // Output register can take a bundle
    logic      reg_dest;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    logic      reg_write;
    logic      mem_to_reg;
    logic      jump;
    logic      jr_jalr;
    logic      hlt;
    mem_size_e mem_size;

    modport ctrl (
        output load, reg_dest, alu_op, alu_src, mem_read, mem_write, branch,
               reg_write, mem_to_reg, jump, jr_jalr, hlt, mem_size,
        input  out_free
    );

    modport sink (
        input  load, reg_dest, alu_op, alu_src, mem_read, mem_write, branch,
               reg_write, mem_to_reg, jump, jr_jalr, hlt, mem_size,
        output out_free
    );

endinterface

//--- hdl/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Data path widths
`define NB_DATA     32
`define NB_PC       32
`define NB_INST     32
`define NB_REG      5              // Register address bits
`define N_REGS      32

// Instruction fields
`define NB_OPCODE   6
`define NB_FUNCT    6
`define NB_SHAMT    5
`define SHAMT_LSB   6              // Shift amount sits in bits 10..6
`define NB_IMM      16
`define NB_TARGET   26             // Jump target field, bits 25..0
`define NB_PC_TOP   4              // PC bits kept in a jump

`endif

//--- hdl/decode_output_reg.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_output_reg (
    input  logic                  i_clock,
    input  logic                  i_reset,
    decode_ctrl_if.sink           ctrl,
    input  logic [`NB_DATA-1:0]   i_data_a,
    input  logic [`NB_DATA-1:0]   i_data_b,
    input  logic [`NB_DATA-1:0]   i_immediate,
    input  logic [`NB_DATA-1:0]   i_shamt,
    input  logic [`NB_PC-1:0]     i_jump_address,
    input  isa_pkg::reg_addr_t    i_rt,
    input  isa_pkg::reg_addr_t    i_rd,
    input  logic [`NB_PC-1:0]     i_pc,
    input  logic                  i_dec_ready,
    output logic                  o_dec_valid,
    output logic                  o_reg_dest,
    output pipe_pkg::alu_op_e     o_alu_op,
    output logic                  o_alu_src,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_branch,
    output logic                  o_reg_write,
    output logic                  o_mem_to_reg,
    output logic                  o_jump,
    output logic                  o_jr_jalr,
    output logic                  o_hlt,
    output pipe_pkg::mem_size_e   o_mem_size,
    output logic [`NB_DATA-1:0]   o_data_a,
    output logic [`NB_DATA-1:0]   o_data_b,
    output logic [`NB_DATA-1:0]   o_immediate,
    output logic [`NB_DATA-1:0]   o_shamt,
    output isa_pkg::reg_addr_t    o_rt,
    output isa_pkg::reg_addr_t    o_rd,
    output logic [`NB_PC-1:0]     o_jump_address,
    output logic [`NB_PC-1:0]     o_pc
);

    // Empty now, or the held bundle leaves on this edge
    assign ctrl.out_free = !o_dec_valid || i_dec_ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_dec_valid <= 1'b0;
        end else if (ctrl.load) begin
            o_dec_valid <= 1'b1;
        end else if (i_dec_ready) begin
            o_dec_valid <= 1'b0;       // Drained with nothing behind it
        end
    end

    always_ff @(posedge i_clock) begin
        if (ctrl.load) begin
            o_reg_dest     <= ctrl.reg_dest;
            o_alu_op       <= ctrl.alu_op;
            o_alu_src      <= ctrl.alu_src;
            o_mem_read     <= ctrl.mem_read;
            o_mem_write    <= ctrl.mem_write;
            o_branch       <= ctrl.branch;
            o_reg_write    <= ctrl.reg_write;
            o_mem_to_reg   <= ctrl.mem_to_reg;
            o_jump         <= ctrl.jump;
            o_jr_jalr      <= ctrl.jr_jalr;
            o_hlt          <= ctrl.hlt;
            o_mem_size     <= ctrl.mem_size;
            o_data_a       <= i_data_a;
            o_data_b       <= i_data_b;
            o_immediate    <= i_immediate;
            o_shamt        <= i_shamt;
            o_rt           <= i_rt;
            o_rd           <= i_rd;
            o_jump_address <= i_jump_address;
            o_pc           <= i_pc;
        end
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_stage (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_inst_valid,
    output logic                  o_inst_ready,
    input  logic [`NB_INST-1:0]   i_inst,
    input  logic [`NB_PC-1:0]     i_next_pc,
    input  logic                  i_wb_write,      // From writeback, no handshake
    input  isa_pkg::reg_addr_t    i_wb_reg,
    input  logic [`NB_DATA-1:0]   i_wb_data,
    output logic                  o_dec_valid,
    input  logic                  i_dec_ready,
    output logic                  o_reg_dest,      // EX
    output pipe_pkg::alu_op_e     o_alu_op,        // EX
    output logic                  o_alu_src,       // EX
    output logic                  o_mem_read,      // MEM
    output logic                  o_mem_write,     // MEM
    output logic                  o_branch,        // MEM
    output logic                  o_reg_write,     // WB
    output logic                  o_mem_to_reg,    // WB
    output logic                  o_jump,
    output logic                  o_jr_jalr,
    output logic                  o_hlt,
    output pipe_pkg::mem_size_e   o_mem_size,      // MEM
    output logic [`NB_DATA-1:0]   o_data_a,
    output logic [`NB_DATA-1:0]   o_data_b,
    output logic [`NB_DATA-1:0]   o_immediate,
    output logic [`NB_DATA-1:0]   o_shamt,
    output isa_pkg::reg_addr_t    o_rt,
    output isa_pkg::reg_addr_t    o_rd,
    output logic [`NB_PC-1:0]     o_jump_address,
    output logic [`NB_PC-1:0]     o_pc
);
    import isa_pkg::*;

    inst_t               inst_fields;
    logic [`NB_DATA-1:0] data_a;
    logic [`NB_DATA-1:0] data_b;
    logic [`NB_DATA-1:0] immediate;
    logic [`NB_DATA-1:0] shamt;
    logic [`NB_PC-1:0]   jump_address;

    decode_ctrl_if u_ctrl_if ();

    assign inst_fields = inst_t'(i_inst);

    decode_control u_control (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_inst_valid (i_inst_valid),
        .o_inst_ready (o_inst_ready),
        .i_opcode     (inst_fields.opcode),
        .i_funct      (inst_fields.funct),
        .ctrl         (u_ctrl_if.ctrl)
    );

    register_bank u_register_bank (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_write      (i_wb_write),
        .i_write_reg  (i_wb_reg),
        .i_write_data (i_wb_data),
        .i_read_reg_a (inst_fields.rs),
        .i_read_reg_b (inst_fields.rt),
        .o_data_a     (data_a),
        .o_data_b     (data_b)
    );

    operand_extend u_operand_extend (
        .i_inst         (i_inst),
        .i_next_pc_top  (i_next_pc[`NB_PC-1 -: `NB_PC_TOP]), // Upper PC bits
        .o_immediate    (immediate),
        .o_shamt        (shamt),
        .o_jump_address (jump_address)
    );

    decode_output_reg u_output_reg (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .ctrl           (u_ctrl_if.sink),
        .i_data_a       (data_a),
        .i_data_b       (data_b),
        .i_immediate    (immediate),
        .i_shamt        (shamt),
        .i_jump_address (jump_address),
        .i_rt           (inst_fields.rt),
        .i_rd           (inst_fields.rd),
        .i_pc           (i_next_pc),
        .i_dec_ready    (i_dec_ready),
        .o_dec_valid    (o_dec_valid),
        .o_reg_dest     (o_reg_dest),
        .o_alu_op       (o_alu_op),
        .o_alu_src      (o_alu_src),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_branch       (o_branch),
        .o_reg_write    (o_reg_write),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_jump         (o_jump),
        .o_jr_jalr      (o_jr_jalr),
        .o_hlt          (o_hlt),
        .o_mem_size     (o_mem_size),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b),
        .o_immediate    (o_immediate),
        .o_shamt        (o_shamt),
        .o_rt           (o_rt),
        .o_rd           (o_rd),
        .o_jump_address (o_jump_address),
        .o_pc           (o_pc)
    );

endmodule

//--- hdl/isa_pkg.sv
`include "decode_defines.svh"

package isa_pkg;

    typedef enum logic [`NB_OPCODE-1:0] {
        OP_RTYPE = 6'h00,              // Operation comes from funct
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f               // Stops the decode stage
    } opcode_e;

    typedef enum logic [`NB_FUNCT-1:0] {
        F_SLL  = 6'h00,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADD  = 6'h20,
        F_SUB  = 6'h22,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_e;

    typedef logic [`NB_REG-1:0] reg_addr_t;

    // R-format view of an instruction, I and J fields overlap rd..funct
    typedef struct packed {
        opcode_e              opcode;
        reg_addr_t            rs;
        reg_addr_t            rt;
        reg_addr_t            rd;
        logic [`NB_SHAMT-1:0] shamt;
        funct_e               funct;
    } inst_t;

endpackage

//--- hdl/operand_extend.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module operand_extend (
    input  logic [`NB_INST-1:0]   i_inst,
    input  logic [`NB_PC_TOP-1:0] i_next_pc_top,
    output logic [`NB_DATA-1:0]   o_immediate,
    output logic [`NB_DATA-1:0]   o_shamt,
    output logic [`NB_PC-1:0]     o_jump_address
);

    // Offsets and arithmetic immediates are signed
    assign o_immediate = {{(`NB_DATA - `NB_IMM){i_inst[`NB_IMM-1]}},
                          i_inst[`NB_IMM-1:0]};

    assign o_shamt = {{(`NB_DATA - `NB_SHAMT){1'b0}},
                      i_inst[`SHAMT_LSB +: `NB_SHAMT]};  // Unsigned

    // Target stays in the current 256 MB region, word aligned
    assign o_jump_address = {i_next_pc_top, i_inst[`NB_TARGET-1:0], 2'b00};

endmodule

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    // Operation requested from the execute stage
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_NOP = 4'hf                 // Nothing to compute
    } alu_op_e;

    // Access width for the memory stage
    typedef enum logic [1:0] {
        SZ_NONE = 2'd0,
        SZ_BYTE = 2'd1,
        SZ_HALF = 2'd2,
        SZ_WORD = 2'd3
    } mem_size_e;

    typedef enum logic {
        ST_RUN     = 1'b0,
        ST_HALTED  = 1'b1              // Left only through reset
    } dec_state_e;

endpackage

//--- hdl/register_bank.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_write,
    input  isa_pkg::reg_addr_t  i_write_reg,
    input  logic [`NB_DATA-1:0] i_write_data,
    input  isa_pkg::reg_addr_t  i_read_reg_a,
    input  isa_pkg::reg_addr_t  i_read_reg_b,
    output logic [`NB_DATA-1:0] o_data_a,
    output logic [`NB_DATA-1:0] o_data_b
);
    import isa_pkg::*;

    logic [`NB_DATA-1:0] regs [`N_REGS];
    logic                write_en;

    assign write_en = i_write && (i_write_reg != '0); // r0 drops writes

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    function automatic logic [`NB_DATA-1:0] read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;                 // Hard-wired zero
        end else if (write_en && (addr == i_write_reg)) begin
            return i_write_data;       // Writeback on the same edge
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_data_a = read_port(i_read_reg_a);
        o_data_b = read_port(i_read_reg_b);
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "Could not remove the old build directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module decode_stage_tb -f verilog.f -o Vdecode_stage_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdecode_stage_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- verilog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode_ctrl_if.sv
hdl/decode_control.sv
hdl/register_bank.sv
hdl/operand_extend.sv
hdl/decode_output_reg.sv
hdl/decode_stage.sv
dv/decode_stage_properties.sv
dv/decode_stage_tb.sv
